// ==== safety_ctrl.f ====
+incdir+verilog
verilog/safety_ctrl_pkg.sv
verilog/mode_sequencer.sv
verilog/single_run_ctrl.sv
verilog/tmr_lane_ctrl.sv
verilog/tmr_error_filter.sv
verilog/safety_ctrl_top.sv
verification/safety_ctrl_chk.sv
verification/safety_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the safety controller testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module safety_ctrl_tb \
  -f safety_ctrl.f

sim_out="$(./obj_dir/Vsafety_ctrl_tb 2>&1)" || true
echo "${sim_out}"

if grep -qx "SIMULATION PASSED" <<< "${sim_out}"; then
  exit 0
fi
exit 1

// ==== verification/safety_ctrl_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Safety controller testbench
// Runs boot, single mode, TMR boot, error recovery and TMR exit, and
// compares the outputs with a reference model on every stable cycle
////////////////////////////////////////////////////////////////////////////

`include "safety_ctrl_config.svh"

module safety_ctrl_tb
  import safety_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N               = `SC_NHARTS;
  localparam int SETTLE_LIMIT    = 8;    // Longest chain is two FSM steps
  localparam int ACK_DELAY_MAX   = 4;
  localparam int ACK_WAITS       = 10;   // Random hart waits over all scenarios
  localparam int SCENARIO_CYCLES = 260;
  localparam int TIMEOUT_CYCLES  = 2 * (SCENARIO_CYCLES + ACK_WAITS * ACK_DELAY_MAX);

  typedef enum int {PH_RESET, PH_BOOT, PH_IDLE, PH_HALT, PH_RUN, PH_RESYNC} phase_e;

  typedef struct packed {
    mode_flags_t  flags;
    logic [N-1:0] halt;
    logic [N-1:0] resync;
  } expect_t;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  hart_status_t hart_status;
  logic [N-1:0] master_core;
  logic [1:0]   safe_cfg;
  logic         start;
  logic         end_sw_routine;
  logic         tmr_error;
  logic         tmr_critical;
  mode_flags_t  flags;
  logic [N-1:0] halt;
  logic [N-1:0] resync;

  // Scenario state seen by the comparing process
  phase_e       phase;
  logic [N-1:0] booted;       // Harts whose halt_ack has arrived
  logic         check_en;
  expect_t      want_now;
  int           err_cnt;
  int           cycle_cnt;
  integer       seed;

  always #5 clk_i = ~clk_i;

  safety_ctrl_top dut0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .hart_status_i    (hart_status),
    .master_core_i    (master_core),
    .safe_cfg_i       (safe_cfg),
    .start_i          (start),
    .end_sw_routine_i (end_sw_routine),
    .tmr_error_i      (tmr_error),
    .tmr_critical_i   (tmr_critical),
    .flags_o          (flags),
    .halt_o           (halt),
    .resync_o         (resync)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic expect_t expected_outputs(input phase_e ph, input logic [N-1:0] acked,
                                               input logic [N-1:0] master,
                                               input logic [1:0] cfg);
    expect_t e;
    e = '0;
    case (ph)
      PH_BOOT: begin
        e.flags.single_bus = 1'b1;
        e.flags.voter_en   = 1'b1;
      end
      PH_IDLE: e.flags.ext_dbg_en = 1'b1;
      PH_HALT, PH_RUN, PH_RESYNC: begin
        if (cfg == `SC_CFG_SINGLE) begin
          e.flags.start_boot = 1'b1;  // Whole of single mode
          if (ph == PH_HALT) e.halt = master;
        end else begin
          // Every lane busy, lanes in start or boot until the acks fall
          e.flags.single_bus = 1'b1;
          e.flags.voter_en   = 1'b1;
          e.flags.start_boot = (ph == PH_HALT);
          if (ph == PH_HALT) e.halt = ~acked;
          if (ph == PH_RESYNC) e.resync = '1;
        end
      end
      default: begin
      end
    endcase
    return e;
  endfunction

  function automatic int ack_delay();
    return 1 + int'($unsigned($random(seed)) % ACK_DELAY_MAX);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      err_cnt++;
      $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, exp_val, act_val, $time);
    end
  endtask

  always @(negedge clk_i) begin
    if (check_en) begin
      want_now = expected_outputs(phase, booted, master_core, safe_cfg);
      check_value("flags_o", 32'(want_now.flags), 32'(flags));
      check_value("halt_o", 32'(want_now.halt), 32'(halt));
      check_value("resync_o", 32'(want_now.resync), 32'(resync));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic hold(input int cycles);
    repeat (cycles) @(posedge clk_i);
  endtask

  task automatic pulse_error();
    tmr_error <= 1'b1;
    @(posedge clk_i);
    tmr_error <= 1'b0;
  endtask

  // Wait for the DUT to reach a phase, then keep checking it
  task automatic settle(input phase_e ph, input logic [N-1:0] acked);
    expect_t want;
    expect_t got;
    int      waited;
    logic    matched;
    check_en = 1'b0;
    waited   = 0;
    @(posedge clk_i);
    want = expected_outputs(ph, acked, master_core, safe_cfg);
    do begin
      @(negedge clk_i);
      got     = {flags, halt, resync};
      matched = (got === want);
      waited++;
    end while (!matched && waited < SETTLE_LIMIT);
    @(posedge clk_i);
    phase  = ph;
    booted = acked;
    if (matched) begin
      check_en = 1'b1;
    end else begin
      err_cnt++;
      $display("Outputs did not reach phase %s within %0d cycles", ph.name(), SETTLE_LIMIT);
    end
  endtask

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Simulation timed out after %0d cycles, %0d error(s)", cycle_cnt, err_cnt);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed      = 32'h1a9fb174;
    err_cnt   = 0;
    cycle_cnt = 0;
    phase     = PH_RESET;
    booted    = '0;
    check_en  = 1'b1;  // All outputs low in reset
    rst_ni         <= 1'b0;
    hart_status    <= '0;
    master_core    <= N'(1) << ($unsigned($random(seed)) % N);
    safe_cfg       <= `SC_CFG_SINGLE;
    start          <= 1'b0;
    end_sw_routine <= 1'b0;
    tmr_error      <= 1'b0;
    tmr_critical   <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Boot until every hart parks in wfi
    settle(PH_BOOT, '0);
    hold(6);
    hart_status.wfi <= '1;
    settle(PH_IDLE, '0);
    hold(3);

    // Reserved code, sequencer stays idle
    safe_cfg <= 2'b10;
    start    <= 1'b1;
    hold(5);
    start    <= 1'b0;
    hold(1);

    // Single mode
    safe_cfg        <= `SC_CFG_SINGLE;
    start           <= 1'b1;
    hart_status.wfi <= '0;
    settle(PH_HALT, '0);
    hold(ack_delay());
    hart_status.halt_ack <= master_core;
    settle(PH_RUN, '0);
    hold(ack_delay());
    hart_status.halt_ack <= '0;
    hold(4);
    end_sw_routine  <= 1'b1;
    hart_status.wfi <= '1;
    start           <= 1'b0;
    settle(PH_IDLE, '0);
    end_sw_routine  <= 1'b0;
    hold(3);

    // TMR boot, one acknowledge at a time
    safe_cfg        <= `SC_CFG_TMR;
    start           <= 1'b1;
    hart_status.wfi <= '0;
    settle(PH_HALT, '0);
    for (int i = 0; i < N; i++) begin
      hold(ack_delay());
      hart_status.halt_ack[i] <= 1'b1;
      settle(PH_HALT, booted | (N'(1) << i));
    end
    hold(ack_delay());
    hart_status.halt_ack <= '0;
    settle(PH_RUN, '1);
    hold(4);

    // Voter error outside a critical section
    pulse_error();
    settle(PH_RESYNC, '1);
    hold(ack_delay());
    hart_status.intc_ack <= '1;
    settle(PH_RESYNC, '1);
    hold(ack_delay());
    hart_status.intc_ack <= '0;
    settle(PH_RUN, '1);
    hold(4);

    // Critical section, first pulse filtered
    tmr_critical <= 1'b1;
    hold(2);
    pulse_error();
    hold(6);
    pulse_error();
    settle(PH_RESYNC, '1);
    hold(ack_delay());
    hart_status.intc_ack <= '1;
    settle(PH_RESYNC, '1);
    hold(ack_delay());
    hart_status.intc_ack <= '0;
    settle(PH_RUN, '1);
    tmr_critical <= 1'b0;
    hold(4);

    // TMR exit, start removed once the lanes are back in idle
    check_en = 1'b0;
    end_sw_routine  <= 1'b1;
    hart_status.wfi <= '1;
    @(posedge clk_i);
    start <= 1'b0;
    settle(PH_IDLE, '0);
    end_sw_routine <= 1'b0;
    hold(4);

    $display("Checks done after %0d cycles, %0d error(s)", cycle_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/safety_ctrl_chk.sv ====
////////////////////////////////////////////////////////////////////////////
// Safety controller checker
// Output invariants and critical-section error filtering, bound into the
// controller top level
////////////////////////////////////////////////////////////////////////////

`include "safety_ctrl_config.svh"

module safety_ctrl_chk
  import safety_ctrl_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  tmr_error_i,
  input logic                  tmr_critical_i,
  input logic                  any_in_sync_i,
  input mode_flags_t           flags_i,
  input logic [`SC_NHARTS-1:0] halt_i,
  input logic [`SC_NHARTS-1:0] resync_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic       err_prev_q;
  logic       err_rise;
  logic [1:0] sync_rises_q;  // Error edges while in sync, saturates at 3

  assign err_rise = tmr_error_i & ~err_prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_prev_q   <= 1'b0;
      sync_rises_q <= '0;
    end else begin
      err_prev_q <= tmr_error_i;
      if (!any_in_sync_i) begin
        sync_rises_q <= '0;
      end else if (err_rise && sync_rises_q != 2'd3) begin
        sync_rises_q <= sync_rises_q + 2'd1;
      end
    end
  end

  a_halt_resync_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(|halt_i && |resync_i))
    else $error("halt and resync requested in the same cycle");

  a_dbg_boot_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(flags_i.ext_dbg_en && flags_i.start_boot))
    else $error("debug enable high while booting");

  // First edge inside a critical section must not start a recovery
  a_crit_first_edge: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tmr_critical_i && any_in_sync_i && err_rise && sync_rises_q == 2'd0 && resync_i == '0
      |=> resync_i == '0)
    else $error("single error edge in critical section raised resync");

endmodule

bind safety_ctrl_top safety_ctrl_chk u_safety_ctrl_chk (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .tmr_error_i    (tmr_error_i),
  .tmr_critical_i (tmr_critical_i),
  .any_in_sync_i  (any_in_sync),
  .flags_i        (flags_o),
  .halt_i         (halt_o),
  .resync_i       (resync_o)
);

// ==== verilog/safety_ctrl_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Safety-mode controller
// Sequencer, single-mode controller, one TMR lane per hart and the error
// filter; lane requests are merged into the cluster outputs here
////////////////////////////////////////////////////////////////////////////

`include "safety_ctrl_config.svh"

module safety_ctrl_top
  import safety_ctrl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  hart_status_t          hart_status_i,
  input  logic [`SC_NHARTS-1:0] master_core_i,
  input  logic [1:0]            safe_cfg_i,
  input  logic                  start_i,
  input  logic                  end_sw_routine_i,
  input  logic                  tmr_error_i,
  input  logic                  tmr_critical_i,

  output mode_flags_t           flags_o,
  output logic [`SC_NHARTS-1:0] halt_o,
  output logic [`SC_NHARTS-1:0] resync_o
);

  logic single_act, tmr_act;
  logic seq_boot, seq_idle;
  logic single_idle;
  logic tmr_all_idle, any_in_sync;
  logic tmr_err;

  logic [`SC_NHARTS-1:0] single_halt;

  lane_req_t             lane_req [`SC_NHARTS];
  logic [`SC_NHARTS-1:0] lane_halt, lane_resync, lane_bus;
  logic [`SC_NHARTS-1:0] lane_voter, lane_boot, lane_sync;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  mode_sequencer u_mode_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .safe_cfg_i     (safe_cfg_i),
    .start_i        (start_i),
    .wfi_i          (hart_status_i.wfi),
    .single_idle_i  (single_idle),
    .tmr_all_idle_i (tmr_all_idle),
    .single_act_o   (single_act),
    .tmr_act_o      (tmr_act),
    .boot_o         (seq_boot),
    .idle_o         (seq_idle)
  );

  single_run_ctrl u_single_run_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .single_act_i     (single_act),
    .start_i          (start_i),
    .end_sw_routine_i (end_sw_routine_i),
    .status_i         (hart_status_i),
    .master_core_i    (master_core_i),
    .single_idle_o    (single_idle),
    .halt_o           (single_halt)
  );

  for (genvar g = 0; g < `SC_NHARTS; g++) begin : g_lane
    tmr_lane_ctrl #(
      .LANE (g)
    ) u_tmr_lane_ctrl (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .tmr_act_i        (tmr_act),
      .start_i          (start_i),
      .end_sw_routine_i (end_sw_routine_i),
      .status_i         (hart_status_i),
      .tmr_err_i        (tmr_err),
      .req_o            (lane_req[g])
    );

    assign lane_halt[g]   = lane_req[g].halt;
    assign lane_resync[g] = lane_req[g].resync_irq;
    assign lane_bus[g]    = lane_req[g].single_bus;
    assign lane_voter[g]  = lane_req[g].voter_en;
    assign lane_boot[g]   = lane_req[g].start_boot;
    assign lane_sync[g]   = lane_req[g].in_sync;
  end

  tmr_error_filter u_tmr_error_filter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tmr_error_i   (tmr_error_i),
    .critical_i    (tmr_critical_i),
    .any_in_sync_i (any_in_sync),
    .err_o         (tmr_err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Merge
  ////////////////////////////////////////////////////////////////////////////

  // A lane holds the single bus in every state but idle and reset
  assign tmr_all_idle = ~|lane_bus;
  assign any_in_sync  = |lane_sync;

  always_comb begin
    flags_o.single_bus = seq_boot | (|lane_bus);
    flags_o.voter_en   = seq_boot | (|lane_voter);
    flags_o.start_boot = single_act | (|lane_boot);
    flags_o.ext_dbg_en = seq_idle;
  end

  assign halt_o   = lane_halt | single_halt;
  assign resync_o = lane_resync;

endmodule

// ==== verilog/tmr_error_filter.sv ====
////////////////////////////////////////////////////////////////////////////
// TMR error filter
// Passes voter errors to the lanes; inside a critical section only a
// second separate rising edge gets through
////////////////////////////////////////////////////////////////////////////

module tmr_error_filter (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic tmr_error_i,
  input  logic critical_i,     // Software in a critical section
  input  logic any_in_sync_i,  // Some lane in TMR_SYNC

  output logic err_o
);

  logic err_prev_q;
  logic err_tog_q;
  logic err_rise;

  assign err_rise = tmr_error_i & ~err_prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_prev_q <= 1'b0;
      err_tog_q  <= 1'b0;
    end else begin
      err_prev_q <= tmr_error_i;
      if (!any_in_sync_i) begin
        err_tog_q <= 1'b0;         // Recovery or idle clears the count
      end else if (err_rise) begin
        err_tog_q <= ~err_tog_q;
      end
    end
  end

  // Outside critical section any error counts
  assign err_o = critical_i ? (err_rise & err_tog_q)
                            : (tmr_error_i | err_tog_q);

endmodule

// ==== verilog/tmr_lane_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// TMR lane controller
// Halts and boots one hart, runs it in lockstep and drives the software
// resynchronisation handshake after a voter error
////////////////////////////////////////////////////////////////////////////

`include "safety_ctrl_config.svh"

module tmr_lane_ctrl
  import safety_ctrl_pkg::*;
#(
  parameter int unsigned LANE = 0  // Hart driven by this lane
) (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         tmr_act_i,
  input  logic         start_i,
  input  logic         end_sw_routine_i,

  input  hart_status_t status_i,
  input  logic         tmr_err_i,  // Filtered voter error

  output lane_req_t    req_o
);

  tmr_state_e state_q, state_d;

  logic all_wfi;
  logic all_intc_ack;
  logic no_intc_ack;

  assign all_wfi      = (status_i.wfi == '1);
  assign all_intc_ack = (status_i.intc_ack == '1);
  assign no_intc_ack  = (status_i.intc_ack == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= TMR_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;

    case (state_q)
      TMR_RESET: state_d = TMR_IDLE;

      TMR_IDLE: begin
        if (tmr_act_i && start_i) state_d = TMR_START;
      end

      // Own hart only for halt and boot
      TMR_START: if (status_i.halt_ack[LANE]) state_d = TMR_BOOT;
      TMR_BOOT:  if (!status_i.halt_ack[LANE]) state_d = TMR_SYNC;

      TMR_SYNC: begin
        if (all_wfi && end_sw_routine_i) begin
          state_d = TMR_IDLE;
        end else if (tmr_err_i) begin
          state_d = TMR_SYNCINTC;
        end
      end

      // Software recovery, whole cluster must take the interrupt
      TMR_SYNCINTC: if (all_intc_ack) state_d = TMR_SWSYNC;
      TMR_SWSYNC:   if (no_intc_ack) state_d = TMR_SYNC;

      default: state_d = TMR_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    req_o = '0;

    case (state_q)
      TMR_START, TMR_BOOT: begin
        req_o.halt       = (state_q == TMR_START);
        req_o.single_bus = 1'b1;
        req_o.voter_en   = 1'b1;
        req_o.start_boot = 1'b1;
      end
      TMR_SYNC: begin
        req_o.single_bus = 1'b1;
        req_o.voter_en   = 1'b1;
        req_o.in_sync    = 1'b1;
      end
      TMR_SYNCINTC, TMR_SWSYNC: begin
        req_o.resync_irq = 1'b1;
        req_o.single_bus = 1'b1;
        req_o.voter_en   = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== verilog/single_run_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Single-mode run controller
// Halts the master hart, lets it run and stops on software end or on
// removal of the external start
////////////////////////////////////////////////////////////////////////////

`include "safety_ctrl_config.svh"

module single_run_ctrl
  import safety_ctrl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  single_act_i,
  input  logic                  start_i,
  input  logic                  end_sw_routine_i,

  input  hart_status_t          status_i,
  input  logic [`SC_NHARTS-1:0] master_core_i,  // One-hot

  output logic                  single_idle_o,
  output logic [`SC_NHARTS-1:0] halt_o
);

  single_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SINGLE_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;

    case (state_q)
      SINGLE_RESET: state_d = SINGLE_IDLE;

      SINGLE_IDLE: begin
        if (single_act_i && start_i && !end_sw_routine_i) state_d = SINGLE_START;
      end

      SINGLE_START: begin
        // Wait for the master alone to acknowledge the halt
        if (status_i.halt_ack == master_core_i) state_d = SINGLE_RUN;
      end

      SINGLE_RUN: begin
        if (end_sw_routine_i && status_i.wfi == '1) begin
          state_d = SINGLE_IDLE;      // Software stop
        end else if (!start_i && status_i.halt_ack == '0 && !end_sw_routine_i) begin
          state_d = SINGLE_SYNC_OFF;  // External stop
        end
      end

      SINGLE_SYNC_OFF: begin
        if (status_i.wfi == '0) state_d = SINGLE_IDLE;
      end

      default: state_d = SINGLE_IDLE;
    endcase
  end

  assign single_idle_o = (state_q == SINGLE_IDLE);
  assign halt_o        = (state_q == SINGLE_START) ? master_core_i : '0;

endmodule

// ==== verilog/mode_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Mode sequencer
// General FSM of the cluster: boot, idle, then single or TMR operation
////////////////////////////////////////////////////////////////////////////

`include "safety_ctrl_config.svh"

module mode_sequencer
  import safety_ctrl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic [1:0]            safe_cfg_i,
  input  logic                  start_i,
  input  logic [`SC_NHARTS-1:0] wfi_i,

  input  logic                  single_idle_i,   // Single controller parked
  input  logic                  tmr_all_idle_i,  // Every lane parked

  output logic                  single_act_o,
  output logic                  tmr_act_o,
  output logic                  boot_o,
  output logic                  idle_o
);

  mode_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;

    case (state_q)
      RESET: begin
        state_d = BOOT;
      end

      BOOT: begin
        // Harts parked in wfi after their boot code
        if (wfi_i == '1) state_d = IDLE;
      end

      IDLE: begin
        if (start_i) begin
          case (safe_cfg_i)
            `SC_CFG_TMR:    state_d = TMR_MODE;
            `SC_CFG_SINGLE: state_d = SINGLE_MODE;
            default:        state_d = IDLE;  // Unsupported codes
          endcase
        end
      end

      SINGLE_MODE: begin
        if (!start_i && single_idle_i) state_d = IDLE;
      end

      TMR_MODE: begin
        if (!start_i && tmr_all_idle_i) state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Moore levels
  assign single_act_o = (state_q == SINGLE_MODE);
  assign tmr_act_o    = (state_q == TMR_MODE);
  assign boot_o       = (state_q == BOOT);
  assign idle_o       = (state_q == IDLE);

endmodule

// ==== verilog/safety_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Safety controller types
// State encodings of the three FSMs and the packed status and request
// bundles shared between the blocks
////////////////////////////////////////////////////////////////////////////

`include "safety_ctrl_config.svh"

package safety_ctrl_pkg;

  // General mode sequencer
  typedef enum logic [2:0] {
    RESET,
    BOOT,
    IDLE,
    SINGLE_MODE,
    TMR_MODE
  } mode_state_e;

  // Single-mode run controller
  typedef enum logic [2:0] {
    SINGLE_RESET,
    SINGLE_IDLE,
    SINGLE_START,
    SINGLE_RUN,
    SINGLE_SYNC_OFF
  } single_state_e;

  // One TMR lane
  typedef enum logic [2:0] {
    TMR_RESET,
    TMR_IDLE,
    TMR_START,
    TMR_BOOT,
    TMR_SYNC,
    TMR_SYNCINTC,
    TMR_SWSYNC
  } tmr_state_e;

  // Per-hart feedback from the cluster
  typedef struct packed {
    logic [`SC_NHARTS-1:0] halt_ack;
    logic [`SC_NHARTS-1:0] wfi;
    logic [`SC_NHARTS-1:0] intc_ack;
  } hart_status_t;

  // Cluster-wide levels
  typedef struct packed {
    logic single_bus;
    logic voter_en;
    logic start_boot;
    logic ext_dbg_en;
  } mode_flags_t;

  // Levels requested by one TMR lane
  typedef struct packed {
    logic halt;
    logic resync_irq;
    logic single_bus;
    logic voter_en;
    logic start_boot;
    logic in_sync;
  } lane_req_t;

endpackage

// ==== verilog/safety_ctrl_config.svh ====
////////////////////////////////////////////////////////////////////////////
// Safety controller configuration
// Cluster size and the safe-configuration codes seen on safe_cfg_i
////////////////////////////////////////////////////////////////////////////

`ifndef SAFETY_CTRL_CONFIG_SVH
`define SAFETY_CTRL_CONFIG_SVH

// Harts in the cluster, sizes every per-hart vector
`define SC_NHARTS 3

// Safe-configuration codes
// 2'b10 and 2'b11 belong to the redundant pair mode, which this
// controller does not implement; the sequencer stays in idle for them
`define SC_CFG_SINGLE 2'b00
`define SC_CFG_TMR    2'b01

`endif
